//--- list.f
common/mem_cfg_pkg.sv
common/axil_pkg.sv
rtl/sp_ram.sv
rtl/mem_arbiter.sv
rtl/axil_mem_port.sv
rtl/shared_mem_top.sv
dv/sp_ram_assert.sv
dv/shared_mem_tb.sv

//--- Makefile
# Verilator build and run of the shared memory testbench

VERILATOR ?= verilator
TOP       ?= shared_mem_tb
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q '\*\* FAIL \*\*' $(LOG) || ! grep -q '\*\* PASS \*\*' $(LOG); then \
	  echo "simulation failed, see $(LOG)"; \
	  exit 1; \
	fi
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- dv/shared_mem_tb.sv
// Testbench for the shared scratch memory, random AXI4-Lite traffic on both ports against a word model

`default_nettype none
`timescale 1ns/1ps

module shared_mem_tb;

  import mem_cfg_pkg::*;
  import axil_pkg::*;

  localparam int DATA_W  = DATA_W_DEF;
  localparam int DEPTH   = DEPTH_DEF;
  localparam int NB      = DATA_W / 8;
  localparam int OFFS_W  = $clog2(NB);
  // Word indices that the AXI address can reach
  localparam int IDX_MAX = 2 ** (AXI_ADDR_W - OFFS_W);
  localparam int HALF_W  = $clog2(DEPTH / 2);
  localparam int NUM_TXN = 16;
  // Cycles allowed for any single wait
  localparam int TIMEOUT = 50;
  localparam logic [31:0] SEED = 32'h250;
  // Galois feedback for x^32 + x^22 + x^2 + x + 1
  localparam logic [31:0] TAPS = 32'h8020_0003;

  logic clk;
  logic arst_n;

  // Master side of both ports, index 0 is s0_ and index 1 is s1_
  logic [AXI_ADDR_W-1:0] awaddr  [NUM_PORTS];
  logic [AXI_ADDR_W-1:0] araddr  [NUM_PORTS];
  logic                  awvalid [NUM_PORTS];
  logic                  wvalid  [NUM_PORTS];
  logic                  bready  [NUM_PORTS];
  logic                  arvalid [NUM_PORTS];
  logic                  rready  [NUM_PORTS];
  logic [DATA_W-1:0]     wdata   [NUM_PORTS];
  logic [NB-1:0]         wstrb   [NUM_PORTS];
  logic                  awready [NUM_PORTS];
  logic                  wready  [NUM_PORTS];
  logic                  bvalid  [NUM_PORTS];
  logic                  arready [NUM_PORTS];
  logic                  rvalid  [NUM_PORTS];
  resp_t                 bresp   [NUM_PORTS];
  resp_t                 rresp   [NUM_PORTS];
  logic [DATA_W-1:0]     rdata   [NUM_PORTS];

  // Reference word model, a word counts only once written
  logic [DATA_W-1:0] model   [DEPTH];
  bit                written [DEPTH];
  logic [31:0]       lfsr_q;

  shared_mem_top #(.DATA_W(DATA_W), .DEPTH(DEPTH)) i_dut (
    .clk(clk), .arst_n(arst_n),
    .s0_awaddr(awaddr[0]), .s0_araddr(araddr[0]), .s0_awvalid(awvalid[0]),
    .s0_wvalid(wvalid[0]), .s0_bready(bready[0]), .s0_arvalid(arvalid[0]),
    .s0_rready(rready[0]), .s0_wdata(wdata[0]), .s0_wstrb(wstrb[0]),
    .s0_awready(awready[0]), .s0_wready(wready[0]), .s0_bvalid(bvalid[0]),
    .s0_arready(arready[0]), .s0_rvalid(rvalid[0]), .s0_bresp(bresp[0]),
    .s0_rresp(rresp[0]), .s0_rdata(rdata[0]),
    .s1_awaddr(awaddr[1]), .s1_araddr(araddr[1]), .s1_awvalid(awvalid[1]),
    .s1_wvalid(wvalid[1]), .s1_bready(bready[1]), .s1_arvalid(arvalid[1]),
    .s1_rready(rready[1]), .s1_wdata(wdata[1]), .s1_wstrb(wstrb[1]),
    .s1_awready(awready[1]), .s1_wready(wready[1]), .s1_bvalid(bvalid[1]),
    .s1_arready(arready[1]), .s1_rvalid(rvalid[1]), .s1_bresp(bresp[1]),
    .s1_rresp(rresp[1]), .s1_rdata(rdata[1])
  );

  initial begin
    clk = 1'b0;
    forever begin
      #4 clk = ~clk;
    end
  end

  // ------------------------------------------------------------
  // Random numbers and model helpers
  // ------------------------------------------------------------

  // One LFSR step per bit taken
  function automatic logic rand_bit();
    logic lsb;
    lsb = lfsr_q[0];
    lfsr_q = lfsr_q >> 1;
    if (lsb) begin
      lfsr_q = lfsr_q ^ TAPS;
    end
    return lsb;
  endfunction

  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], rand_bit()};
    end
    return v;
  endfunction

  function automatic logic [DATA_W-1:0] rand_word();
    logic [DATA_W-1:0] w;
    for (int i = 0; i < DATA_W; i++) begin
      w[i] = rand_bit();
    end
    return w;
  endfunction

  // Strobed bytes come from the new data, the rest stay
  function automatic logic [DATA_W-1:0] merge_word(logic [DATA_W-1:0] old_w,
                                                   logic [DATA_W-1:0] new_w,
                                                   logic [NB-1:0] strb);
    logic [DATA_W-1:0] w;
    w = old_w;
    for (int b = 0; b < NB; b++) begin
      if (strb[b]) begin
        w[b*8 +: 8] = new_w[b*8 +: 8];
      end
    end
    return w;
  endfunction

  function automatic logic [AXI_ADDR_W-1:0] byte_addr(int idx);
    return AXI_ADDR_W'(idx * NB);
  endfunction

  function automatic string port_sig(int p, string s);
    return $sformatf("s%0d_%s", p, s);
  endfunction

  // ------------------------------------------------------------
  // Compare tasks
  // ------------------------------------------------------------

  task automatic fail_now(string msg);
    $display("%s", msg);
    $display("** FAIL **");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_flag(string name, logic got, logic exp);
    if (got !== exp) begin
      fail_now($sformatf("error at %0t: %s is %b, expected %b", $time, name, got, exp));
    end
  endtask

  task automatic check_resp(string name, resp_t got, resp_t exp);
    if (got !== exp) begin
      fail_now($sformatf("error at %0t: %s is %b, expected %b", $time, name, got, exp));
    end
  endtask

  task automatic check_data(string name, logic [DATA_W-1:0] got, logic [DATA_W-1:0] exp);
    if (got !== exp) begin
      fail_now($sformatf("error at %0t: %s is %h, expected %h", $time, name, got, exp));
    end
  endtask

  // ------------------------------------------------------------
  // AXI4-Lite master tasks
  // ------------------------------------------------------------

  // Waits for AR or AW/W ready, then drops the valids after the transfer edge
  task automatic wait_ready(int p, logic is_rd);
    int cnt;
    cnt = 0;
    #1;
    while (is_rd ? !arready[p] : !awready[p]) begin
      cnt++;
      if (cnt > TIMEOUT) begin
        fail_now($sformatf("port %0d accepted no address within %0d cycles", p, TIMEOUT));
      end
      @(negedge clk);
      #1;
    end
    // AW and W are taken together
    if (!is_rd) begin
      check_flag(port_sig(p, "wready"), wready[p], 1'b1);
    end
    @(negedge clk);
    arvalid[p] = 1'b0;
    awvalid[p] = 1'b0;
    wvalid[p]  = 1'b0;
  endtask

  // Waits for B or R, holds ready low for stall cycles, then takes it
  task automatic take_response(int p, logic is_rd, int stall,
                               output resp_t resp, output logic [DATA_W-1:0] data);
    int cnt;
    string vname;
    cnt = 0;
    vname = port_sig(p, is_rd ? "rvalid" : "bvalid");
    #1;
    while (!(is_rd ? rvalid[p] : bvalid[p])) begin
      cnt++;
      if (cnt > TIMEOUT) begin
        fail_now($sformatf("port %0d gave no response within %0d cycles", p, TIMEOUT));
      end
      @(negedge clk);
      #1;
    end
    resp = is_rd ? rresp[p] : bresp[p];
    data = rdata[p];
    // New requests offered here must be refused
    for (int s = 0; s < stall; s++) begin
      @(negedge clk);
      arvalid[p] = 1'b1;
      awvalid[p] = 1'b1;
      wvalid[p]  = 1'b1;
      #1;
      check_flag(vname, is_rd ? rvalid[p] : bvalid[p], 1'b1);
      check_resp(port_sig(p, is_rd ? "rresp" : "bresp"), is_rd ? rresp[p] : bresp[p], resp);
      if (is_rd) begin
        check_data(port_sig(p, "rdata"), rdata[p], data);
      end
      check_flag(port_sig(p, "arready"), arready[p], 1'b0);
      check_flag(port_sig(p, "awready"), awready[p], 1'b0);
      check_flag(port_sig(p, "wready"), wready[p], 1'b0);
    end
    @(negedge clk);
    arvalid[p] = 1'b0;
    awvalid[p] = 1'b0;
    wvalid[p]  = 1'b0;
    bready[p]  = !is_rd;
    rready[p]  = is_rd;
    #1;
    check_flag(vname, is_rd ? rvalid[p] : bvalid[p], 1'b1);
    @(negedge clk);
    bready[p] = 1'b0;
    rready[p] = 1'b0;
  endtask

  task automatic axi_write(int p, int idx, logic [DATA_W-1:0] data, logic [NB-1:0] strb,
                           resp_t exp, int stall);
    resp_t             resp;
    logic [DATA_W-1:0] held_data;
    @(negedge clk);
    awaddr[p]  = byte_addr(idx);
    wdata[p]   = data;
    wstrb[p]   = strb;
    awvalid[p] = 1'b1;
    wvalid[p]  = 1'b1;
    wait_ready(p, 1'b0);
    take_response(p, 1'b0, stall, resp, held_data);
    check_resp(port_sig(p, "bresp"), resp, exp);
    // Model follows at the write response
    if (exp == RESP_OKAY) begin
      model[idx]   = merge_word(model[idx], data, strb);
      written[idx] = 1'b1;
    end
  endtask

  task automatic axi_read(int p, int idx, resp_t exp, int stall);
    resp_t             resp;
    logic [DATA_W-1:0] data;
    @(negedge clk);
    araddr[p]  = byte_addr(idx);
    arvalid[p] = 1'b1;
    wait_ready(p, 1'b1);
    take_response(p, 1'b1, stall, resp, data);
    check_resp(port_sig(p, "rresp"), resp, exp);
    // Error reads carry zero data
    if (exp != RESP_OKAY) begin
      check_data(port_sig(p, "rdata"), data, '0);
    end else if (written[idx]) begin
      check_data(port_sig(p, "rdata"), data, model[idx]);
    end
  endtask

  // First write of a word uses all strobes so no byte stays undefined
  task automatic write_random(int p, int idx, int stall);
    logic [NB-1:0] strb;
    strb = written[idx] ? NB'(rand_bits(NB)) : {NB{1'b1}};
    axi_write(p, idx, rand_word(), strb, RESP_OKAY, stall);
  endtask

  // Mixed traffic on one half of the memory
  task automatic port_traffic(int p, int n);
    int idx;
    int stall;
    for (int i = 0; i < n; i++) begin
      idx   = p * (DEPTH / 2) + int'(rand_bits(HALF_W));
      stall = int'(rand_bits(2));
      if (rand_bit() && written[idx]) begin
        axi_read(p, idx, RESP_OKAY, stall);
      end else begin
        write_random(p, idx, stall);
      end
    end
  endtask

  // ------------------------------------------------------------
  // Test sequence
  // ------------------------------------------------------------

  initial begin
    int idx;
    int bad;
    int idx_q [$];
    lfsr_q = SEED;
    arst_n = 1'b0;
    for (int p = 0; p < NUM_PORTS; p++) begin
      awaddr[p]  = '0;
      araddr[p]  = '0;
      awvalid[p] = 1'b0;
      wvalid[p]  = 1'b0;
      bready[p]  = 1'b0;
      arvalid[p] = 1'b0;
      rready[p]  = 1'b0;
      wdata[p]   = '0;
      wstrb[p]   = '0;
    end
    for (int i = 0; i < DEPTH; i++) begin
      written[i] = 1'b0;
    end
    repeat (2) @(negedge clk);
    arst_n = 1'b1;

    // Quiet outputs after reset
    repeat (3) begin
      @(negedge clk);
      #1;
      for (int p = 0; p < NUM_PORTS; p++) begin
        check_flag(port_sig(p, "awready"), awready[p], 1'b0);
        check_flag(port_sig(p, "wready"), wready[p], 1'b0);
        check_flag(port_sig(p, "arready"), arready[p], 1'b0);
        check_flag(port_sig(p, "bvalid"), bvalid[p], 1'b0);
        check_flag(port_sig(p, "rvalid"), rvalid[p], 1'b0);
      end
    end

    // Strobed writes, then read back on the same port
    for (int p = 0; p < NUM_PORTS; p++) begin
      idx_q.delete();
      for (int i = 0; i < NUM_TXN; i++) begin
        idx = int'(rand_bits($clog2(DEPTH)));
        idx_q.push_back(idx);
        write_random(p, idx, 0);
      end
      foreach (idx_q[i]) begin
        axi_read(p, idx_q[i], RESP_OKAY, 0);
      end
    end

    // Out of range, then the word a truncated index would hit
    for (int p = 0; p < NUM_PORTS; p++) begin
      for (int i = 0; i < 8; i++) begin
        bad = DEPTH + (int'(rand_bits(AXI_ADDR_W)) % (IDX_MAX - DEPTH));
        axi_write(p, bad, rand_word(), {NB{1'b1}}, RESP_SLVERR, 0);
        axi_read(p, bad, RESP_SLVERR, 0);
        if (written[bad % DEPTH]) begin
          axi_read(p, bad % DEPTH, RESP_OKAY, 0);
        end
      end
    end
    // Sweep of every written word
    for (int i = 0; i < DEPTH; i++) begin
      if (written[i]) begin
        axi_read(i % NUM_PORTS, i, RESP_OKAY, 0);
      end
    end

    // Both ports at once, disjoint halves
    fork
      port_traffic(0, 40);
      port_traffic(1, 40);
    join

    // Long back-pressure on both response channels
    for (int p = 0; p < NUM_PORTS; p++) begin
      for (int i = 0; i < 8; i++) begin
        idx = p * (DEPTH / 2) + int'(rand_bits(HALF_W));
        write_random(p, idx, 1 + int'(rand_bits(3)));
        axi_read(p, idx, RESP_OKAY, 1 + int'(rand_bits(3)));
      end
    end

    $display("** PASS **");
    $finish;
  end

endmodule

`default_nettype wire

//--- dv/sp_ram_assert.sv
// Concurrent checks on the shared single-port RAM, bound into every sp_ram instance

`default_nettype none
`timescale 1ns/1ps

module sp_ram_assert #(
  parameter int DATA_W = mem_cfg_pkg::DATA_W_DEF,
  parameter int DEPTH  = mem_cfg_pkg::DEPTH_DEF
) (
  input  logic                     clk,
  input  logic                     write_en,
  input  logic [DATA_W/8-1:0]      be,
  input  logic [$clog2(DEPTH)-1:0] address,
  input  logic [DATA_W-1:0]        data_in,
  input  logic [DATA_W-1:0]        data_out
);

  localparam int NB = DATA_W / 8;

  // be widened to a bit mask
  logic [DATA_W-1:0]        be_mask;
  // Previous cycle's access
  logic                     wr_q;
  logic [$clog2(DEPTH)-1:0] wr_addr_q;
  logic [DATA_W-1:0]        wr_data_q;
  logic [DATA_W-1:0]        wr_mask_q;
  // Read of the just written word is pending
  logic                     chk_q;
  logic [DATA_W-1:0]        exp_q;
  logic [DATA_W-1:0]        mask_q;

  always_comb begin
    for (int b = 0; b < NB; b++) begin
      be_mask[b*8 +: 8] = {8{be[b]}};
    end
  end

  // ------------------------------------------------------------
  // Write followed by a read of the same word
  // ------------------------------------------------------------

  always_ff @(posedge clk) begin
    wr_q      <= write_en;
    wr_addr_q <= address;
    wr_data_q <= data_in;
    wr_mask_q <= be_mask;
    chk_q     <= wr_q && !write_en && (address == wr_addr_q);
    exp_q     <= wr_data_q;
    mask_q    <= wr_mask_q;
  end

  a_addr_range: assert property (@(posedge clk) int'(address) < DEPTH)
    else $error("RAM address at or beyond depth");

  a_ctrl_known: assert property (@(posedge clk) !$isunknown(write_en) && !$isunknown(address))
    else $error("RAM write enable or address unknown");

  a_hold_on_write: assert property (@(posedge clk) write_en |=> $stable(data_out))
    else $error("RAM read data changed on a write cycle");

  // Strobed bytes only, the others keep older contents
  a_write_read: assert property (@(posedge clk) chk_q |-> ((data_out ^ exp_q) & mask_q) == '0)
    else $error("RAM read after write returned other data");

endmodule

bind sp_ram sp_ram_assert #(.DATA_W(DATA_W), .DEPTH(DEPTH)) i_ram_assert (
  .clk(clk), .write_en(write_en), .be(be), .address(address),
  .data_in(data_in), .data_out(data_out)
);

`default_nettype wire

//--- rtl/shared_mem_top.sv
// Top level of the shared scratch memory: two AXI4-Lite slave ports, arbiter and RAM

`default_nettype none
`timescale 1ns/1ps

module shared_mem_top #(
  parameter int DATA_W = mem_cfg_pkg::DATA_W_DEF,
  parameter int DEPTH  = mem_cfg_pkg::DEPTH_DEF
) (
  input  logic                               clk,
  input  logic                               arst_n,
  // ------------------------------------------------------------
  // Port 0, CPU side
  // ------------------------------------------------------------
  input  logic [mem_cfg_pkg::AXI_ADDR_W-1:0] s0_awaddr, s0_araddr,
  input  logic                               s0_awvalid, s0_wvalid, s0_bready,
  input  logic                               s0_arvalid, s0_rready,
  input  logic [DATA_W-1:0]                  s0_wdata,
  input  logic [DATA_W/8-1:0]                s0_wstrb,
  output logic                               s0_awready, s0_wready, s0_bvalid,
  output logic                               s0_arready, s0_rvalid,
  output axil_pkg::resp_t                    s0_bresp, s0_rresp,
  output logic [DATA_W-1:0]                  s0_rdata,
  // ------------------------------------------------------------
  // Port 1, DMA side
  // ------------------------------------------------------------
  input  logic [mem_cfg_pkg::AXI_ADDR_W-1:0] s1_awaddr, s1_araddr,
  input  logic                               s1_awvalid, s1_wvalid, s1_bready,
  input  logic                               s1_arvalid, s1_rready,
  input  logic [DATA_W-1:0]                  s1_wdata,
  input  logic [DATA_W/8-1:0]                s1_wstrb,
  output logic                               s1_awready, s1_wready, s1_bvalid,
  output logic                               s1_arready, s1_rvalid,
  output axil_pkg::resp_t                    s1_bresp, s1_rresp,
  output logic [DATA_W-1:0]                  s1_rdata
);

  import mem_cfg_pkg::*;

  // Per-port request bundle
  logic                     req       [NUM_PORTS];
  logic                     req_we    [NUM_PORTS];
  logic [$clog2(DEPTH)-1:0] req_addr  [NUM_PORTS];
  logic [DATA_W-1:0]        req_wdata [NUM_PORTS];
  logic [DATA_W/8-1:0]      req_be    [NUM_PORTS];
  logic                     gnt       [NUM_PORTS];

  // RAM side, read data goes to both ports
  logic                     mem_we;
  logic [DATA_W/8-1:0]      mem_be;
  logic [$clog2(DEPTH)-1:0] mem_addr;
  logic [DATA_W-1:0]        mem_wdata;
  logic [DATA_W-1:0]        mem_rdata;

  axil_mem_port #(.DATA_W(DATA_W), .DEPTH(DEPTH)) i_port0 (
    .clk(clk), .arst_n(arst_n),
    .awaddr(s0_awaddr), .awvalid(s0_awvalid), .awready(s0_awready),
    .wdata(s0_wdata), .wstrb(s0_wstrb), .wvalid(s0_wvalid), .wready(s0_wready),
    .bresp(s0_bresp), .bvalid(s0_bvalid), .bready(s0_bready),
    .araddr(s0_araddr), .arvalid(s0_arvalid), .arready(s0_arready),
    .rdata(s0_rdata), .rresp(s0_rresp), .rvalid(s0_rvalid), .rready(s0_rready),
    .req(req[0]), .req_we(req_we[0]), .req_addr(req_addr[0]),
    .req_wdata(req_wdata[0]), .req_be(req_be[0]),
    .gnt(gnt[0]), .mem_rdata(mem_rdata)
  );

  axil_mem_port #(.DATA_W(DATA_W), .DEPTH(DEPTH)) i_port1 (
    .clk(clk), .arst_n(arst_n),
    .awaddr(s1_awaddr), .awvalid(s1_awvalid), .awready(s1_awready),
    .wdata(s1_wdata), .wstrb(s1_wstrb), .wvalid(s1_wvalid), .wready(s1_wready),
    .bresp(s1_bresp), .bvalid(s1_bvalid), .bready(s1_bready),
    .araddr(s1_araddr), .arvalid(s1_arvalid), .arready(s1_arready),
    .rdata(s1_rdata), .rresp(s1_rresp), .rvalid(s1_rvalid), .rready(s1_rready),
    .req(req[1]), .req_we(req_we[1]), .req_addr(req_addr[1]),
    .req_wdata(req_wdata[1]), .req_be(req_be[1]),
    .gnt(gnt[1]), .mem_rdata(mem_rdata)
  );

  mem_arbiter #(.DATA_W(DATA_W), .DEPTH(DEPTH)) i_arb (
    .clk(clk), .arst_n(arst_n),
    .req(req), .req_we(req_we), .req_addr(req_addr),
    .req_wdata(req_wdata), .req_be(req_be), .gnt(gnt),
    .mem_we(mem_we), .mem_be(mem_be), .mem_addr(mem_addr), .mem_wdata(mem_wdata)
  );

  sp_ram #(.DATA_W(DATA_W), .DEPTH(DEPTH)) i_ram (
    .clk(clk), .write_en(mem_we), .be(mem_be), .address(mem_addr),
    .data_in(mem_wdata), .data_out(mem_rdata)
  );

endmodule

`default_nettype wire

//--- rtl/axil_mem_port.sv
// AXI4-Lite slave port that turns one read or write into a RAM request and returns its response

`default_nettype none
`timescale 1ns/1ps

module axil_mem_port #(
  parameter int DATA_W = mem_cfg_pkg::DATA_W_DEF,
  parameter int DEPTH  = mem_cfg_pkg::DEPTH_DEF
) (
  input  logic                               clk,
  input  logic                               arst_n,
  // Write address and write data
  input  logic [mem_cfg_pkg::AXI_ADDR_W-1:0] awaddr,
  input  logic                               awvalid,
  output logic                               awready,
  input  logic [DATA_W-1:0]                  wdata,
  input  logic [DATA_W/8-1:0]                wstrb,
  input  logic                               wvalid,
  output logic                               wready,
  // Write response
  output axil_pkg::resp_t                    bresp,
  output logic                               bvalid,
  input  logic                               bready,
  // Read address and read data
  input  logic [mem_cfg_pkg::AXI_ADDR_W-1:0] araddr,
  input  logic                               arvalid,
  output logic                               arready,
  output logic [DATA_W-1:0]                  rdata,
  output axil_pkg::resp_t                    rresp,
  output logic                               rvalid,
  input  logic                               rready,
  // Request towards the arbiter
  output logic                               req,
  output logic                               req_we,
  output logic [$clog2(DEPTH)-1:0]           req_addr,
  output logic [DATA_W-1:0]                  req_wdata,
  output logic [DATA_W/8-1:0]                req_be,
  input  logic                               gnt,
  input  logic [DATA_W-1:0]                  mem_rdata
);

  import mem_cfg_pkg::*;
  import axil_pkg::*;

  localparam int NB     = DATA_W / 8;
  // Byte offset bits dropped from the AXI address
  localparam int OFFS_W = $clog2(NB);
  localparam int IDX_W  = AXI_ADDR_W - OFFS_W;
  localparam int ADDR_W = $clog2(DEPTH);
  // One extra bit so a full-range depth still compares correctly
  localparam logic [IDX_W:0] DEPTH_LIM = (IDX_W + 1)'(DEPTH);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_REQ,
    ST_RESP
  } state_t;

  // Control state
  state_t             state_q;
  logic               is_rd_q;
  // High in the cycle after our own read grant
  logic               rd_fresh_q;
  resp_t              resp_q;

  // Captured request and read data
  logic [ADDR_W-1:0]  addr_q;
  logic [DATA_W-1:0]  wdata_q;
  logic [NB-1:0]      be_q;
  logic [DATA_W-1:0]  rdata_q;

  logic               take_rd;
  logic               take_wr;
  logic [IDX_W-1:0]   sel_idx;
  logic               sel_ok;

  // ------------------------------------------------------------
  // Acceptance and range check
  // ------------------------------------------------------------

  always_comb begin
    // Only idle accepts, a pending read beats a pending write
    take_rd = (state_q == ST_IDLE) && arvalid;
    take_wr = (state_q == ST_IDLE) && !arvalid && awvalid && wvalid;
    // Word index of whichever channel is taken
    sel_idx = arvalid ? araddr[AXI_ADDR_W-1:OFFS_W] : awaddr[AXI_ADDR_W-1:OFFS_W];
    sel_ok  = {1'b0, sel_idx} < DEPTH_LIM;
  end

  assign arready = take_rd;
  // AW and W handshake together
  assign awready = take_wr;
  assign wready  = take_wr;

  // ------------------------------------------------------------
  // FSM
  // ------------------------------------------------------------

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state_q    <= ST_IDLE;
      is_rd_q    <= 1'b0;
      rd_fresh_q <= 1'b0;
      resp_q     <= RESP_OKAY;
    end else begin
      rd_fresh_q <= 1'b0;
      case (state_q)
        ST_IDLE: begin
          if (take_rd || take_wr) begin
            is_rd_q <= take_rd;
            resp_q  <= sel_ok ? RESP_OKAY : RESP_SLVERR;
            // Out of range goes straight to the response
            state_q <= sel_ok ? ST_REQ : ST_RESP;
          end
        end
        ST_REQ: begin
          // Access happens on this edge
          if (gnt) begin
            state_q    <= ST_RESP;
            rd_fresh_q <= is_rd_q;
          end
        end
        ST_RESP: begin
          // Stay busy until the master takes the response
          if (is_rd_q ? rready : bready) begin
            state_q <= ST_IDLE;
          end
        end
        default: begin
          state_q <= ST_IDLE;
        end
      endcase
    end
  end

  // Payload capture
  always_ff @(posedge clk) begin
    if (take_rd || take_wr) begin
      addr_q <= ADDR_W'(sel_idx);
    end
    if (take_wr) begin
      wdata_q <= wdata;
      be_q    <= wstrb;
    end
    // Zero covers out-of-range reads, in-range reads overwrite it
    if (take_rd) begin
      rdata_q <= '0;
    end else if (rd_fresh_q) begin
      rdata_q <= mem_rdata;
    end
  end

  // ------------------------------------------------------------
  // Outputs
  // ------------------------------------------------------------

  assign req       = (state_q == ST_REQ);
  assign req_we    = req && !is_rd_q;
  assign req_addr  = addr_q;
  assign req_wdata = wdata_q;
  assign req_be    = be_q;

  assign bvalid = (state_q == ST_RESP) && !is_rd_q;
  assign rvalid = (state_q == ST_RESP) && is_rd_q;
  assign bresp  = resp_q;
  assign rresp  = resp_q;
  // RAM output used directly in the first response cycle, latched copy after
  assign rdata  = rd_fresh_q ? mem_rdata : rdata_q;

endmodule

`default_nettype wire

//--- rtl/mem_arbiter.sv
// Round-robin arbiter between the two port requests, drives the shared RAM from the winner

`default_nettype none
`timescale 1ns/1ps

module mem_arbiter #(
  parameter int DATA_W = mem_cfg_pkg::DATA_W_DEF,
  parameter int DEPTH  = mem_cfg_pkg::DEPTH_DEF
) (
  input  logic                     clk,
  input  logic                     arst_n,
  // Requests, one entry per peer port
  input  logic                     req       [mem_cfg_pkg::NUM_PORTS],
  input  logic                     req_we    [mem_cfg_pkg::NUM_PORTS],
  input  logic [$clog2(DEPTH)-1:0] req_addr  [mem_cfg_pkg::NUM_PORTS],
  input  logic [DATA_W-1:0]        req_wdata [mem_cfg_pkg::NUM_PORTS],
  input  logic [DATA_W/8-1:0]      req_be    [mem_cfg_pkg::NUM_PORTS],
  output logic                     gnt       [mem_cfg_pkg::NUM_PORTS],
  // RAM side
  output logic                     mem_we,
  output logic [DATA_W/8-1:0]      mem_be,
  output logic [$clog2(DEPTH)-1:0] mem_addr,
  output logic [DATA_W-1:0]        mem_wdata
);

  import mem_cfg_pkg::*;

  // Port that won the most recent grant
  port_idx_t last_q;
  // Port chosen this cycle
  port_idx_t win;
  // At least one port is requesting
  logic      req_any;

  // ------------------------------------------------------------
  // Winner selection
  // ------------------------------------------------------------

  always_comb begin
    req_any = req[0] || req[1];
    if (req[0] && req[1]) begin
      // Contention, the port that lost last time goes first
      win = ~last_q;
    end else if (req[1]) begin
      win = port_idx_t'(1);
    end else begin
      win = port_idx_t'(0);
    end
  end

  // Grant goes back in the same cycle
  always_comb begin
    for (int i = 0; i < NUM_PORTS; i++) begin
      gnt[i] = req_any && (win == port_idx_t'(i));
    end
  end

  // ------------------------------------------------------------
  // RAM mux
  // ------------------------------------------------------------

  // Idle cycles keep we, be and address at known zero values
  assign mem_we    = req_any && req_we[win];
  assign mem_be    = req_any ? req_be[win] : '0;
  assign mem_addr  = req_any ? req_addr[win] : '0;
  assign mem_wdata = req_wdata[win];

  // Remember the winner for the next contention
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      last_q <= port_idx_t'(0);
    end else if (req_any) begin
      last_q <= win;
    end
  end

endmodule

`default_nettype wire

//--- rtl/sp_ram.sv
// Single-port RAM with byte write enables and a registered read port, shared by both AXI ports

`default_nettype none
`timescale 1ns/1ps

module sp_ram #(
  parameter int DATA_W = mem_cfg_pkg::DATA_W_DEF,
  parameter int DEPTH  = mem_cfg_pkg::DEPTH_DEF
) (
  input  logic                     clk,
  input  logic                     write_en,
  input  logic [DATA_W/8-1:0]      be,
  input  logic [$clog2(DEPTH)-1:0] address,
  input  logic [DATA_W-1:0]        data_in,
  output logic [DATA_W-1:0]        data_out
);

  localparam int NB = DATA_W / 8;

  // Word storage, contents undefined until written
  logic [DATA_W-1:0] mem [DEPTH];

  // ------------------------------------------------------------
  // Write or read, one per cycle
  // ------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (write_en) begin
      // Byte lanes with be set are merged into the word
      for (int b = 0; b < NB; b++) begin
        if (be[b]) begin
          mem[address][b*8 +: 8] <= data_in[b*8 +: 8];
        end
      end
      // data_out keeps its last read value here
    end else begin
      // Read data appears one cycle after the read edge
      data_out <= mem[address];
    end
  end

endmodule

`default_nettype wire

//--- common/axil_pkg.sv
// AXI4-Lite response encodings used by the slave ports and the testbench

`default_nettype none

package axil_pkg;

  // ------------------------------------------------------------
  // Response channel
  // ------------------------------------------------------------

  // BRESP / RRESP field
  typedef logic [1:0] resp_t;

  // Normal access completed
  localparam resp_t RESP_OKAY = 2'b00;

  // Slave error
  // Returned for word indices at or beyond the RAM depth
  // The memory is not touched in that case
  localparam resp_t RESP_SLVERR = 2'b10;

endpackage

`default_nettype wire

//--- common/mem_cfg_pkg.sv
// Memory geometry defaults and peer port index type, imported by the RTL and the testbench

`default_nettype none

package mem_cfg_pkg;

  // ------------------------------------------------------------
  // Geometry defaults
  // ------------------------------------------------------------

  // Word width in bits, must stay a multiple of 8
  localparam int DATA_W_DEF = 32;

  // Words in the shared RAM
  localparam int DEPTH_DEF = 256;

  // AXI byte address width
  // Caps the usable depth at 2**AXI_ADDR_W bytes
  localparam int AXI_ADDR_W = 12;

  // ------------------------------------------------------------
  // Peer ports
  // ------------------------------------------------------------

  // One CPU side and one DMA side slave
  localparam int NUM_PORTS = 2;

  // Selects one peer port, used for grant bookkeeping
  typedef logic [$clog2(NUM_PORTS)-1:0] port_idx_t;

endpackage

`default_nettype wire
